// ==== hdl/cpu_defines.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Constants shared by the CPU blocks: reset vector, zero page
// and ALU operation codes. Include in any file that uses them.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Low byte of the reset vector, high byte follows
`define CPU_RESET_VECTOR 16'hFFFC

// High address byte of zero-page accesses
`define CPU_ZERO_PAGE 8'h00

// Logic ops share 2'b11 on top, opcode bits 6:5 below
`define CPU_OP_OR   4'b1100
`define CPU_OP_AND  4'b1101
`define CPU_OP_EOR  4'b1110

// Adder ops, SUB inverts the B input
`define CPU_OP_ADD  4'b0011
`define CPU_OP_SUB  4'b0111

// A input straight through
`define CPU_OP_PASS 4'b1111

`endif

// ==== hdl/cpu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared across the CPU: data and address widths, the
// bundles passed between blocks, and the sequencer states.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpu_pkg;

    typedef logic [7:0]  cpu_byte_t;    // Data byte
    typedef logic [15:0] cpu_addr_t;    // Bus address
    typedef logic [3:0]  alu_op_t;      // ALU operation code
    typedef logic [1:0]  reg_sel_t;     // Register index

    localparam reg_sel_t SEL_A = 2'd0;
    localparam reg_sel_t SEL_X = 2'd1;
    localparam reg_sel_t SEL_Y = 2'd2;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } flags_t;

    // Per-instruction flags, latched at decode
    typedef struct packed {
        reg_sel_t   src_reg;        // Register read by the op
        reg_sel_t   dst_reg;        // Register written at next decode
        logic       load_reg;       // Result goes to dst_reg
        logic       load_only;      // LDA/LDX/LDY
        logic       store;          // STA/STX/STY
        logic       adc_sbc;        // ADC or SBC
        logic       compare;        // CMP
        logic       inc;            // INX/INY carry in
        logic       index_none;     // Register op, no memory operand
        logic       clc;
        logic       sec;
        alu_op_t    op;             // Main ALU op
        logic [2:0] cond_code;      // Branch condition bits
    } ctrl_t;

    typedef struct packed {
        alu_op_t   op;
        cpu_byte_t ai;
        cpu_byte_t bi;
        logic      ci;
    } alu_req_t;

    typedef struct packed {
        cpu_byte_t result;
        logic      co;
        logic      v;
        logic      z;
        logic      n;
    } alu_res_t;

    typedef enum logic [3:0] {
        DECODE, FETCH, REG, ZP0, ABS0, ABS1,
        BRA0, BRA1, BRA2, JMP0, JMP1
    } state_t;

endpackage

// ==== hdl/cpu_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cycle sequencer of the CPU. Walks each addressing mode state
// by state, owns the PC and drives the memory bus, the ALU
// inputs and the register select.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_sequencer (
    input  logic                clk,
    input  logic                reset_l,
    input  cpu_pkg::cpu_byte_t  data_in,
    input  cpu_pkg::ctrl_t      ctrl,
    input  cpu_pkg::alu_res_t   alu_res,
    input  cpu_pkg::cpu_byte_t  reg_out,
    input  cpu_pkg::flags_t     flags,
    input  logic                cond_true,
    output cpu_pkg::cpu_addr_t  addr,
    output cpu_pkg::cpu_byte_t  data_out,
    output logic                we,
    output cpu_pkg::alu_req_t   alu_req,
    output logic                decode,
    output logic                reg_write,
    output cpu_pkg::reg_sel_t   reg_sel
);
    import cpu_pkg::*;

    state_t    state;
    cpu_addr_t pc;
    cpu_addr_t ab_hold;         // Address of the previous cycle
    logic      reset_fetch;     // First cycle after reset
    logic      backwards;       // Branch offset sign
    cpu_addr_t pc_base;
    logic      pc_inc;

    // Address mux
    always_comb begin
        case (state)
            ABS1, JMP1: addr = {data_in, alu_res.result};
            BRA1:       addr = {ab_hold[15:8], alu_res.result};    // Same page
            BRA2:       addr = {alu_res.result, ab_hold[7:0]};     // Page fixed up
            ZP0:        addr = {`CPU_ZERO_PAGE, data_in};
            REG:        addr = ab_hold;     // Re-read next opcode
            default:    addr = pc;
        endcase
    end

    assign data_out  = reg_out;
    assign we        = (state == ZP0 || state == ABS1) && ctrl.store;
    assign decode    = (state == DECODE);
    assign reg_write = (state == DECODE);   // Previous op retires here
    assign reg_sel   = (state == DECODE) ? ctrl.dst_reg : ctrl.src_reg;

    // PC base and increment
    always_comb begin
        pc_base = (state == JMP1 || state == BRA1 || state == BRA2) ? addr : pc;
        case (state)
            DECODE, ABS0, FETCH, BRA0, JMP1, BRA2: pc_inc = 1'b1;
            JMP0:    pc_inc = reset_fetch;                  // FFFC to FFFD
            BRA1:    pc_inc = alu_res.co ~^ backwards;      // No page cross
            default: pc_inc = 1'b0;
        endcase
    end

    // ALU input selection
    always_comb begin
        alu_req.op = `CPU_OP_ADD;
        alu_req.ai = 8'h00;
        alu_req.bi = data_in;
        alu_req.ci = 1'b0;
        case (state)
            FETCH, REG: begin
                alu_req.op = ctrl.op;
                alu_req.ai = ctrl.load_only ? 8'h00 : reg_out;
                alu_req.bi = ctrl.index_none ? 8'h00 : data_in;
                if (ctrl.compare)
                    alu_req.ci = 1'b1;
                else if (ctrl.load_only)
                    alu_req.ci = 1'b0;
                else if (ctrl.index_none)
                    alu_req.ci = ctrl.inc;
                else
                    alu_req.ci = flags.c;   // ADC/SBC carry
            end
            BRA0: alu_req.ai = pc[7:0];     // Offset plus PCL
            BRA1: begin
                alu_req.op = backwards ? `CPU_OP_SUB : `CPU_OP_ADD;
                alu_req.ai = ab_hold[15:8];
                alu_req.bi = 8'h00;
                alu_req.ci = alu_res.co;
            end
            default: ;                      // Latch data_in as address low byte
        endcase
    end

    always_ff @(posedge clk or negedge reset_l) begin
        if (!reset_l) begin
            state       <= JMP0;
            pc          <= `CPU_RESET_VECTOR;
            ab_hold     <= '0;
            reset_fetch <= 1'b1;
            backwards   <= 1'b0;
        end else begin
            pc          <= pc_base + 16'(pc_inc);
            ab_hold     <= addr;
            reset_fetch <= 1'b0;
            if (state == BRA0)
                backwards <= data_in[7];
            case (state)
                DECODE: begin
                    casez (data_in)
                        8'h4C:         state <= JMP0;
                        8'bzzz1_0000:  state <= BRA0;
                        8'b1010_00z0,               // LDY, LDX imm
                        8'b0zz0_1001,               // ORA..ADC imm
                        8'b11z0_1001,               // CMP, SBC imm
                        8'hA9:         state <= FETCH;
                        8'bzzz0_0101,               // A column zp
                        8'b10z0_01z0:  state <= ZP0;    // X, Y zp
                        8'b10z0_11z0,
                        8'b10z0_1101:  state <= ABS0;
                        default:       state <= REG;    // Reg ops and no-ops
                    endcase
                end
                ZP0:     state <= FETCH;
                ABS0:    state <= ABS1;
                ABS1:    state <= FETCH;
                BRA0:    state <= cond_true ? BRA1 : DECODE;
                BRA1:    state <= (alu_res.co ^ backwards) ? BRA2 : DECODE;
                JMP0:    state <= reset_fetch ? JMP0 : JMP1;
                default: state <= DECODE;   // FETCH, REG, BRA2, JMP1
            endcase
        end
    end

endmodule

// ==== hdl/cpu_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder. Latches the control flags of the opcode
// on the decode pulse; they hold until the next decode.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_decoder (
    input  logic               clk,
    input  logic               reset_l,
    input  logic               decode,
    input  cpu_pkg::cpu_byte_t data_in,
    output cpu_pkg::ctrl_t     ctrl
);
    import cpu_pkg::*;

    ctrl_t nxt;

    always_comb begin
        nxt    = '0;                    // No-op unless matched
        nxt.op = `CPU_OP_ADD;
        casez (data_in)
            8'hA9, 8'hA5, 8'hAD: begin  // LDA
                nxt.load_reg  = 1'b1;
                nxt.load_only = 1'b1;
            end
            8'hA2, 8'hA6, 8'hAE: begin  // LDX
                nxt.load_reg  = 1'b1;
                nxt.load_only = 1'b1;
                nxt.dst_reg   = SEL_X;
            end
            8'hA0, 8'hA4, 8'hAC: begin  // LDY
                nxt.load_reg  = 1'b1;
                nxt.load_only = 1'b1;
                nxt.dst_reg   = SEL_Y;
            end
            8'h85, 8'h8D: nxt.store = 1'b1;
            8'h86, 8'h8E: begin
                nxt.store   = 1'b1;
                nxt.src_reg = SEL_X;
            end
            8'h84, 8'h8C: begin
                nxt.store   = 1'b1;
                nxt.src_reg = SEL_Y;
            end
            8'h69, 8'h65: begin         // ADC
                nxt.load_reg = 1'b1;
                nxt.adc_sbc  = 1'b1;
            end
            8'hE9, 8'hE5: begin         // SBC
                nxt.load_reg = 1'b1;
                nxt.adc_sbc  = 1'b1;
                nxt.op       = `CPU_OP_SUB;
            end
            8'hC9, 8'hC5: begin         // CMP
                nxt.compare = 1'b1;
                nxt.op      = `CPU_OP_SUB;
            end
            8'b0zz0_0101, 8'b0zz0_1001: begin   // ORA, AND, EOR
                nxt.load_reg = 1'b1;
                nxt.op       = {2'b11, data_in[6:5]};
            end
            8'hE8, 8'hCA, 8'hC8, 8'h88: begin   // INX, DEX, INY, DEY
                nxt.load_reg   = 1'b1;
                nxt.index_none = 1'b1;
                nxt.src_reg    = data_in[1] ? SEL_X : (data_in[5] ? SEL_X : SEL_Y);
                nxt.dst_reg    = nxt.src_reg;
                nxt.inc        = data_in[6] & ~data_in[1];     // INX, INY count up
                nxt.op         = nxt.inc ? `CPU_OP_ADD : `CPU_OP_SUB;
            end
            8'hAA, 8'hA8, 8'h8A, 8'h98: begin   // TAX, TAY, TXA, TYA
                nxt.load_reg   = 1'b1;
                nxt.index_none = 1'b1;
                nxt.src_reg    = data_in[5] ? SEL_A : (data_in[1] ? SEL_X : SEL_Y);
                nxt.dst_reg    = !data_in[5] ? SEL_A : (data_in[1] ? SEL_X : SEL_Y);
            end
            8'h18: begin
                nxt.clc        = 1'b1;
                nxt.index_none = 1'b1;
            end
            8'h38: begin
                nxt.sec        = 1'b1;
                nxt.index_none = 1'b1;
            end
            8'bzzz1_0000: nxt.cond_code = data_in[7:5];     // Branches
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset_l) begin
        if (!reset_l)
            ctrl <= '0;
        else if (decode)
            ctrl <= nxt;
    end

endmodule

// ==== hdl/cpu_alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8-bit ALU with adder and logic ops. Result and flags are
// registered, so they appear the cycle after the request.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_alu (
    input  logic              clk,
    input  logic              reset_l,
    input  cpu_pkg::alu_req_t alu_req,
    output cpu_pkg::alu_res_t alu_res
);
    import cpu_pkg::*;

    cpu_byte_t  bi_eff;
    logic [8:0] sum;
    cpu_byte_t  res;
    logic       ovf;

    always_comb begin
        bi_eff = (alu_req.op == `CPU_OP_SUB) ? ~alu_req.bi : alu_req.bi;
        sum    = {1'b0, alu_req.ai} + {1'b0, bi_eff} + 9'(alu_req.ci);
        ovf    = (alu_req.ai[7] == bi_eff[7]) && (sum[7] != alu_req.ai[7]);
        case (alu_req.op)
            `CPU_OP_OR:  res = alu_req.ai | alu_req.bi;
            `CPU_OP_AND: res = alu_req.ai & alu_req.bi;
            `CPU_OP_EOR: res = alu_req.ai ^ alu_req.bi;
            `CPU_OP_ADD,
            `CPU_OP_SUB: res = sum[7:0];
            `CPU_OP_PASS: res = alu_req.ai;
            default:     res = alu_req.ai;
        endcase
    end

    always_ff @(posedge clk or negedge reset_l) begin
        if (!reset_l) begin
            alu_res <= '0;
        end else begin
            alu_res.result <= res;
            alu_res.co     <= sum[8];          // Also no-borrow on SUB
            alu_res.v      <= ovf;
            alu_res.z      <= (res == 8'h00);
            alu_res.n      <= res[7];
        end
    end

endmodule

// ==== hdl/cpu_reg_status.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// A, X and Y registers with the N, V, Z, C status flags.
// Written at decode from the previous ALU result, and gives the
// branch condition for the current instruction.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpu_reg_status (
    input  logic               clk,
    input  logic               reset_l,
    input  logic               reg_write,
    input  cpu_pkg::reg_sel_t  reg_sel,
    input  cpu_pkg::ctrl_t     ctrl,
    input  cpu_pkg::alu_res_t  alu_res,
    output cpu_pkg::cpu_byte_t reg_out,
    output cpu_pkg::flags_t    flags,
    output logic               cond_true
);
    import cpu_pkg::*;

    cpu_byte_t a_reg;
    cpu_byte_t x_reg;
    cpu_byte_t y_reg;

    always_comb begin
        case (reg_sel)
            SEL_X:   reg_out = x_reg;
            SEL_Y:   reg_out = y_reg;
            default: reg_out = a_reg;
        endcase
    end

    always_ff @(posedge clk or negedge reset_l) begin
        if (!reset_l) begin
            a_reg <= '0;
            x_reg <= '0;
            y_reg <= '0;
            flags <= '0;
        end else if (reg_write) begin
            if (ctrl.load_reg) begin
                case (reg_sel)
                    SEL_X:   x_reg <= alu_res.result;
                    SEL_Y:   y_reg <= alu_res.result;
                    default: a_reg <= alu_res.result;
                endcase
            end
            if (ctrl.adc_sbc || ctrl.compare)
                flags.c <= alu_res.co;
            else if (ctrl.sec)
                flags.c <= 1'b1;
            else if (ctrl.clc)
                flags.c <= 1'b0;
            if (ctrl.adc_sbc)
                flags.v <= alu_res.v;
            if (ctrl.load_reg || ctrl.compare) begin
                flags.z <= alu_res.z;
                flags.n <= alu_res.n;
            end
        end
    end

    // Bits 7:6 pick the flag, bit 5 the polarity
    always_comb begin
        case (ctrl.cond_code)
            3'b000:  cond_true = ~flags.n;     // BPL
            3'b001:  cond_true = flags.n;      // BMI
            3'b010:  cond_true = ~flags.v;
            3'b011:  cond_true = flags.v;
            3'b100:  cond_true = ~flags.c;     // BCC
            3'b101:  cond_true = flags.c;      // BCS
            3'b110:  cond_true = ~flags.z;     // BNE
            default: cond_true = flags.z;      // BEQ
        endcase
    end

endmodule

// ==== hdl/cpu_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the CPU. Connect to a synchronous memory that
// returns mem[addr] one clock later and writes when we is high.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpu_top (
    input  logic               clk,
    input  logic               reset_l,
    input  cpu_pkg::cpu_byte_t data_in,
    output cpu_pkg::cpu_addr_t addr,
    output cpu_pkg::cpu_byte_t data_out,
    output logic               we
);
    import cpu_pkg::*;

    ctrl_t     ctrl;
    alu_req_t  alu_req;
    alu_res_t  alu_res;
    cpu_byte_t reg_out;
    flags_t    flags;
    logic      cond_true;
    logic      decode;
    logic      reg_write;
    reg_sel_t  reg_sel;

    cpu_sequencer cpu_sequencer_i (
        .clk       (clk),
        .reset_l   (reset_l),
        .data_in   (data_in),
        .ctrl      (ctrl),
        .alu_res   (alu_res),
        .reg_out   (reg_out),
        .flags     (flags),
        .cond_true (cond_true),
        .addr      (addr),
        .data_out  (data_out),
        .we        (we),
        .alu_req   (alu_req),
        .decode    (decode),
        .reg_write (reg_write),
        .reg_sel   (reg_sel)
    );

    cpu_decoder cpu_decoder_i (
        .clk     (clk),
        .reset_l (reset_l),
        .decode  (decode),
        .data_in (data_in),
        .ctrl    (ctrl)
    );

    cpu_alu cpu_alu_i (
        .clk     (clk),
        .reset_l (reset_l),
        .alu_req (alu_req),
        .alu_res (alu_res)
    );

    cpu_reg_status cpu_reg_status_i (
        .clk       (clk),
        .reset_l   (reset_l),
        .reg_write (reg_write),
        .reg_sel   (reg_sel),
        .ctrl      (ctrl),
        .alu_res   (alu_res),
        .reg_out   (reg_out),
        .flags     (flags),
        .cond_true (cond_true)
    );

endmodule

// ==== sim/cpu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the CPU top level. Loads one small program per
// table row at 16'h0200, resets the DUT, waits for the first
// store and checks its address and data against the 6502 rules.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int          NUM_ROWS     = 30;
    localparam int          ROW_CYCLES   = 100;
    localparam int          MAX_CYCLES   = ROW_CYCLES * NUM_ROWS;
    localparam int          WAIT_CYCLES  = 80;     // Store wait per row
    localparam int          RESET_CYCLES = 4;
    localparam logic [31:0] SEED         = 32'h90fd49a4;

    localparam cpu_addr_t PROG      = 16'h0200;    // Reset vector target
    localparam cpu_addr_t PAGE_CODE = 16'h02FB;    // Branch at 02FD lands on 0303
    localparam cpu_addr_t FAR_CODE  = 16'h7A30;
    localparam cpu_addr_t ABS_SRC   = 16'h0480;
    localparam cpu_addr_t ABS_RES   = 16'h0340;
    localparam cpu_byte_t ZP_SRC    = 8'h20;
    localparam cpu_byte_t ZP_RES    = 8'h40;

    // Program kinds, loads are 0..8 as register * 3 + mode
    localparam int K_ALU_FIRST  = 9;               // ADC SBC AND ORA EOR immediate
    localparam int K_ALU_ZP     = 14;              // Same five, zero page
    localparam int K_TAX_INX    = 19;
    localparam int K_DEY_ZERO   = 20;
    localparam int K_CMP_BEQ    = 21;
    localparam int K_CMP_BCS    = 22;
    localparam int K_CMP_BMI    = 23;
    localparam int K_DEX_LOOP   = 24;
    localparam int K_PAGE_CROSS = 25;
    localparam int K_JMP_FAR    = 26;
    localparam int NUM_KINDS    = 27;

    typedef struct packed {
        logic [4:0] kind;
        cpu_byte_t  a;
        cpu_byte_t  b;
        cpu_addr_t  exp_addr;
        cpu_byte_t  exp_val;
    } row_t;

    logic       clk;
    logic       reset_l;
    cpu_byte_t  data_in;
    cpu_addr_t  addr;
    cpu_byte_t  data_out;
    logic       we;

    cpu_byte_t  mem [0:65535];
    row_t       rows [NUM_ROWS];
    int         errors;
    int         cycle_count;
    logic       wr_seen;                           // First store of the row captured
    cpu_addr_t  wr_addr;
    cpu_byte_t  wr_data;
    cpu_addr_t  mem_addr_q;
    cpu_addr_t  load_ptr;
    logic [31:0] rng_state;

    cpu_top cpu_top_i (
        .clk      (clk),
        .reset_l  (reset_l),
        .data_in  (data_in),
        .addr     (addr),
        .data_out (data_out),
        .we       (we)
    );

    always #2 clk = ~clk;

    // Synchronous memory, read data shows up 1 ns after the edge
    always @(posedge clk) begin
        mem_addr_q = addr;
        if (we) begin
            mem[mem_addr_q] = data_out;
            if (!wr_seen) begin
                wr_seen = 1'b1;
                wr_addr = mem_addr_q;
                wr_data = data_out;
            end
        end
        #1 data_in = mem[mem_addr_q];
    end

    // Watchdog over the whole table
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the table did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors: %0d", errors);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cpu_byte_t load_opcode(input int k);
        case (k)
            0:       return 8'hA9;                 // LDA imm, zp, abs
            1:       return 8'hA5;
            2:       return 8'hAD;
            3:       return 8'hA2;                 // LDX
            4:       return 8'hA6;
            5:       return 8'hAE;
            6:       return 8'hA0;                 // LDY
            7:       return 8'hA4;
            default: return 8'hAC;
        endcase
    endfunction

    function automatic cpu_byte_t store_opcode(input int reg_i, input logic absolute);
        case (reg_i)
            0:       return absolute ? 8'h8D : 8'h85;
            1:       return absolute ? 8'h8E : 8'h86;
            default: return absolute ? 8'h8C : 8'h84;
        endcase
    endfunction

    // Immediate forms, zero page is 4 lower
    function automatic cpu_byte_t alu_opcode(input int alu_i);
        case (alu_i)
            0:       return 8'h69;
            1:       return 8'hE9;
            2:       return 8'h29;
            3:       return 8'h09;
            default: return 8'h49;
        endcase
    endfunction

    function automatic string kind_name(input int k);
        string base;
        string mode;
        mode = "";
        if (k < K_ALU_FIRST) begin
            case (k / 3)
                0:       base = "lda";
                1:       base = "ldx";
                default: base = "ldy";
            endcase
            mode = (k % 3 == 0) ? "_imm" : ((k % 3 == 1) ? "_zp" : "_abs");
        end else if (k < K_TAX_INX) begin
            case ((k - K_ALU_FIRST) % 5)
                0:       base = "adc";
                1:       base = "sbc";
                2:       base = "and";
                3:       base = "ora";
                default: base = "eor";
            endcase
            mode = (k >= K_ALU_ZP) ? "_zp" : "_imm";
        end else begin
            case (k)
                K_TAX_INX:    base = "tax_inx";
                K_DEY_ZERO:   base = "dey_zero";
                K_CMP_BEQ:    base = "cmp_beq";
                K_CMP_BCS:    base = "cmp_bcs";
                K_CMP_BMI:    base = "cmp_bmi";
                K_DEX_LOOP:   base = "dex_loop";
                K_PAGE_CROSS: base = "page_cross";
                default:      base = "jmp_far";
            endcase
        end
        return {base, mode};
    endfunction

    // Result by the 6502 rules, carry set up by CLC or SEC before the op
    function automatic row_t make_row(input int k, input cpu_byte_t a, input cpu_byte_t b);
        row_t      r;
        cpu_byte_t diff;
        r.kind = 5'(k);
        r.a    = (k == K_DEX_LOOP) ? (a % 8'd8) + 8'd1 : a;    // Loop count 1..8
        r.b    = b;
        diff   = r.a - r.b;
        if (k < K_ALU_FIRST) begin
            r.exp_val = r.a;
        end else if (k < K_TAX_INX) begin
            case ((k - K_ALU_FIRST) % 5)
                0:       r.exp_val = r.a + r.b;
                1:       r.exp_val = diff;
                2:       r.exp_val = r.a & r.b;
                3:       r.exp_val = r.a | r.b;
                default: r.exp_val = r.a ^ r.b;
            endcase
        end else begin
            case (k)
                K_TAX_INX:    r.exp_val = r.a + 8'd2;
                K_DEY_ZERO:   r.exp_val = 8'hFF;
                K_CMP_BEQ:    r.exp_val = (r.a == r.b) ? 8'h01 : 8'h02;
                K_CMP_BCS:    r.exp_val = (r.a >= r.b) ? 8'h01 : 8'h02;    // No borrow
                K_CMP_BMI:    r.exp_val = diff[7] ? 8'h01 : 8'h02;
                K_PAGE_CROSS: r.exp_val = 8'h01;                            // Z set by LDY #0
                default:      r.exp_val = r.a;                              // Loop count, JMP
            endcase
        end
        if ((k < K_ALU_FIRST && k % 3 == 1) || k == K_JMP_FAR)
            r.exp_addr = ABS_RES;
        else
            r.exp_addr = {8'h00, ZP_RES};
        return r;
    endfunction

    task automatic build_table();
        cpu_byte_t a;
        cpu_byte_t b;
        rng_state = SEED;
        for (int i = 0; i < NUM_ROWS; i++) begin
            rng_state = xorshift32(rng_state);
            a = rng_state[7:0];
            rng_state = xorshift32(rng_state);
            b = rng_state[7:0];
            if (i < NUM_KINDS)
                rows[i] = make_row(i, a, b);
            else if (i == NUM_KINDS)
                rows[i] = make_row(K_CMP_BEQ, a, a);    // Equal operands, branch taken
            else if (i == NUM_KINDS + 1)
                rows[i] = make_row(K_CMP_BCS, a, a);
            else
                rows[i] = make_row(K_DEX_LOOP, a, b);
        end
    endtask

    task automatic emit(input cpu_byte_t v);
        mem[load_ptr] = v;
        load_ptr++;
    endtask

    task automatic emit2(input cpu_byte_t op, input cpu_byte_t operand);
        emit(op);
        emit(operand);
    endtask

    task automatic emit_word(input cpu_addr_t w);
        emit(w[7:0]);
        emit(w[15:8]);
    endtask

    task automatic load_program(input row_t r);
        int        k;
        int        alu_i;
        cpu_addr_t self_addr;
        k = int'(r.kind);
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'h00;
        mem[16'hFFFC] = PROG[7:0];
        mem[16'hFFFD] = PROG[15:8];
        load_ptr = PROG;
        if (k < K_ALU_FIRST) begin
            mem[{8'h00, ZP_SRC}] = r.a;
            mem[ABS_SRC] = r.a;
            emit(load_opcode(k));
            if (k % 3 == 0)
                emit(r.a);
            else if (k % 3 == 1)
                emit(ZP_SRC);
            else
                emit_word(ABS_SRC);
            if (k % 3 == 1) begin                  // Zero-page load, absolute store
                emit(store_opcode(k / 3, 1'b1));
                emit_word(ABS_RES);
            end else begin
                emit2(store_opcode(k / 3, 1'b0), ZP_RES);
            end
        end else if (k < K_TAX_INX) begin
            alu_i = (k - K_ALU_FIRST) % 5;
            mem[{8'h00, ZP_SRC}] = r.b;
            emit((alu_i == 1) ? 8'h38 : 8'h18);    // SEC for SBC, CLC otherwise
            emit2(8'hA9, r.a);
            if (k >= K_ALU_ZP)
                emit2(alu_opcode(alu_i) - 8'h04, ZP_SRC);
            else
                emit2(alu_opcode(alu_i), r.b);
            emit2(8'h85, ZP_RES);
        end else begin
            case (k)
                K_TAX_INX: begin
                    emit2(8'hA9, r.a);
                    emit2(8'hAA, 8'hE8);           // TAX, INX
                    emit2(8'hE8, 8'h8A);           // INX, TXA
                    emit2(8'h85, ZP_RES);
                end
                K_DEY_ZERO: begin
                    emit2(8'hA0, 8'h00);
                    emit(8'h88);
                    emit2(8'h84, ZP_RES);
                end
                K_CMP_BEQ, K_CMP_BCS, K_CMP_BMI: begin
                    emit2(8'hA9, r.a);
                    emit2(8'hC9, r.b);
                    emit2((k == K_CMP_BEQ) ? 8'hF0 : ((k == K_CMP_BCS) ? 8'hB0 : 8'h30),
                          8'h04);                  // Skip the marker 2 store
                    emit2(8'hA9, 8'h02);
                    emit2(8'h85, ZP_RES);
                    emit2(8'hA9, 8'h01);
                    emit2(8'h85, ZP_RES);
                end
                K_DEX_LOOP: begin
                    emit2(8'hA2, r.a);
                    emit2(8'hA0, 8'h00);
                    emit2(8'hC8, 8'hCA);           // INY, DEX
                    emit2(8'hD0, 8'hFC);           // Back to INY
                    emit2(8'h84, ZP_RES);
                end
                K_PAGE_CROSS: begin
                    emit(8'h4C);
                    emit_word(PAGE_CODE);
                    load_ptr = PAGE_CODE;
                    emit2(8'hA0, 8'h00);
                    emit2(8'hF0, 8'h04);           // From 02FF into page 03
                    emit2(8'hA9, 8'h02);
                    emit2(8'h85, ZP_RES);
                    emit2(8'hA9, 8'h01);
                    emit2(8'h85, ZP_RES);
                end
                default: begin
                    emit2(8'hA9, r.a);
                    emit(8'h4C);
                    emit_word(FAR_CODE);
                    load_ptr = FAR_CODE;
                    emit(8'h8D);
                    emit_word(ABS_RES);
                end
            endcase
        end
        self_addr = load_ptr;                      // Park on JMP to itself
        emit(8'h4C);
        emit_word(self_addr);
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual == expected) else begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic run_row(input int i);
        string     name;
        cpu_addr_t vec_addr;
        int        waited;
        name = $sformatf("%s_%0d", kind_name(int'(rows[i].kind)), i);
        @(posedge clk);
        #1;
        reset_l = 1'b0;
        wr_seen = 1'b0;
        load_program(rows[i]);
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            check_value("reset_we", 16'h0000, {15'h0000, we});
        end
        @(posedge clk);
        #1 reset_l = 1'b1;
        for (int j = 0; j < 3; j++) begin          // FFFC, FFFD, then the vector
            vec_addr = (j == 0) ? 16'hFFFC : ((j == 1) ? 16'hFFFD : PROG);
            @(negedge clk);
            check_value("reset_vector", vec_addr, addr);
            check_value("reset_vector_we", 16'h0000, {15'h0000, we});
        end
        waited = 0;
        while (!wr_seen && waited < WAIT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        assert (wr_seen) else begin
            errors++;
            $display("Row %s wrote nothing to memory within %0d cycles", name, WAIT_CYCLES);
        end
        if (wr_seen) begin
            check_value({name, "_addr"}, rows[i].exp_addr, wr_addr);
            check_value({name, "_data"}, {8'h00, rows[i].exp_val}, {8'h00, wr_data});
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset_l     = 1'b0;
        data_in     = 8'h00;
        errors      = 0;
        cycle_count = 0;
        wr_seen     = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        build_table();
        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i);
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/cpu_sequencer.sv
hdl/cpu_decoder.sv
hdl/cpu_alu.sv
hdl/cpu_reg_status.sv
hdl/cpu_top.sv
sim/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the CPU testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
RTL_TOP   ?= cpu_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
